//--- source/rv_isa_pkg.sv
/*
 * ISA description for the nibble-serial core: opcodes, funct3 codes,
 * ALU operations and register file dimensions.
 * Shared by the decoder, the core and the testbench model.
 */
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN          = 32;
    localparam int NUM_REGS      = 16;
    localparam int REG_ADDR_BITS = 4;
    localparam int NIBBLES       = XLEN / 4;  // One nibble per clock

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Pass forwards the second operand unchanged, which is how LUI gets its result
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_pass
    } alu_op_t;

    typedef enum logic {
        src_reg,
        src_imm
    } src_b_t;

endpackage

`default_nettype wire

//--- source/fetch_pkg.sv
/*
 * Dimensions of the halfword fetch path and its credit counter.
 * The fetch source starts out with FETCH_DEPTH credits.
 */
`default_nettype none

package fetch_pkg;

    localparam int FETCH_DEPTH = 4;
    localparam int HALF_W      = 16;
    localparam int CREDIT_W    = 3;  // Holds 0 to FETCH_DEPTH

endpackage

`default_nettype wire

//--- source/instr_prefetch.sv
/*
 * Halfword prefetch buffer. Halfwords from the fetch source land in a small
 * FIFO and are moved one per cycle into a two-half assembly register.
 * Every move hands one credit back to the source on the next cycle.
 */
`default_nettype none

module instr_prefetch (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           fetch_valid,
    input  wire  [fetch_pkg::HALF_W-1:0]  fetch_data,
    input  wire                           instr_take,
    output logic                          fetch_credit,
    output logic                          instr_avail,
    output logic [31:0]                   instr_word
);

    localparam int PTR_W = $clog2(fetch_pkg::FETCH_DEPTH);
    localparam logic [fetch_pkg::CREDIT_W-1:0] FULL_COUNT =
        fetch_pkg::FETCH_DEPTH[fetch_pkg::CREDIT_W-1:0];

    logic [fetch_pkg::HALF_W-1:0]   fifo_mem [fetch_pkg::FETCH_DEPTH];
    logic [PTR_W-1:0]               wr_ptr;
    logic [PTR_W-1:0]               rd_ptr;
    logic [fetch_pkg::CREDIT_W-1:0] fifo_count;

    logic [fetch_pkg::HALF_W-1:0]   asm_lo;
    logic [fetch_pkg::HALF_W-1:0]   asm_hi;
    logic [1:0]                     half_cnt;  // Two halves held make a full word
    logic                           move;

    // Head of the FIFO is read directly, so a move can follow the write by one cycle
    assign move = (fifo_count != '0) && !half_cnt[1];

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            fifo_mem[wr_ptr] <= fetch_data;
        end
        if (move) begin
            if (half_cnt[0]) begin
                asm_hi <= fifo_mem[rd_ptr];
            end else begin
                asm_lo <= fifo_mem[rd_ptr];  // Lower half always arrives first
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fifo_count   <= '0;
            half_cnt     <= '0;
            fetch_credit <= 1'b0;
        end else begin
            if (fetch_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (move) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({fetch_valid, move})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase

            // A take only happens with a full word, when no move is possible
            if (instr_take) begin
                half_cnt <= '0;
            end else if (move) begin
                half_cnt <= half_cnt + 1'b1;
            end

            fetch_credit <= move;
        end
    end

    assign instr_avail = half_cnt[1];
    assign instr_word  = {asm_hi, asm_lo};

    // The source may only send while it holds credits, so the FIFO never overflows
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        fetch_valid |-> fifo_count != FULL_COUNT);

    a_take_when_avail: assert property (@(posedge clk) disable iff (!rstn)
        instr_take |-> instr_avail);

endmodule

`default_nettype wire

//--- source/instr_decoder.sv
/*
 * Combinational decoder for the supported subset: register ALU ops,
 * ALU immediates and LUI. Anything else is flagged as illegal.
 */
`default_nettype none

module instr_decoder (
    input  wire  [31:0]                          instr_word,
    output rv_isa_pkg::alu_op_t                  alu_op,
    output rv_isa_pkg::src_b_t                   src_b,
    output logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rs1,
    output logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rs2,
    output logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rd,
    output logic [rv_isa_pkg::XLEN-1:0]          imm,
    output logic                                 illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rd_f;
    logic [4:0] rs1_f;
    logic [4:0] rs2_f;

    function automatic logic reg_ok(input logic [4:0] field);
        return int'(field) < rv_isa_pkg::NUM_REGS;
    endfunction

    assign opcode = instr_word[6:0];
    assign rd_f   = instr_word[11:7];
    assign funct3 = instr_word[14:12];
    assign rs1_f  = instr_word[19:15];
    assign rs2_f  = instr_word[24:20];
    assign funct7 = instr_word[31:25];

    always_comb begin
        alu_op  = rv_isa_pkg::op_add;
        src_b   = rv_isa_pkg::src_reg;
        rs1     = rs1_f[rv_isa_pkg::REG_ADDR_BITS-1:0];
        rs2     = rs2_f[rv_isa_pkg::REG_ADDR_BITS-1:0];
        rd      = rd_f[rv_isa_pkg::REG_ADDR_BITS-1:0];
        imm     = {{20{instr_word[31]}}, instr_word[31:20]};
        illegal = 1'b0;

        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                illegal = !reg_ok(rd_f) || !reg_ok(rs1_f) || !reg_ok(rs2_f);
                case (funct3)
                    // Only bit 30 of funct7 may be set, and only for SUB
                    rv_isa_pkg::F3_ADD_SUB: begin
                        alu_op = instr_word[30] ? rv_isa_pkg::op_sub : rv_isa_pkg::op_add;
                        illegal = illegal || ({funct7[6], funct7[4:0]} != '0);
                    end
                    rv_isa_pkg::F3_XOR: alu_op = rv_isa_pkg::op_xor;
                    rv_isa_pkg::F3_OR:  alu_op = rv_isa_pkg::op_or;
                    rv_isa_pkg::F3_AND: alu_op = rv_isa_pkg::op_and;
                    default:            illegal = 1'b1;
                endcase
                if (funct3 != rv_isa_pkg::F3_ADD_SUB && funct7 != '0) begin
                    illegal = 1'b1;
                end
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                src_b   = rv_isa_pkg::src_imm;
                illegal = !reg_ok(rd_f) || !reg_ok(rs1_f);
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: alu_op = rv_isa_pkg::op_add;
                    rv_isa_pkg::F3_XOR:     alu_op = rv_isa_pkg::op_xor;
                    rv_isa_pkg::F3_OR:      alu_op = rv_isa_pkg::op_or;
                    rv_isa_pkg::F3_AND:     alu_op = rv_isa_pkg::op_and;
                    default:                illegal = 1'b1;  // Shifts and compares
                endcase
            end
            rv_isa_pkg::OPC_LUI: begin
                alu_op  = rv_isa_pkg::op_pass;
                src_b   = rv_isa_pkg::src_imm;
                rs1     = '0;
                imm     = {instr_word[31:12], 12'b0};
                illegal = !reg_ok(rd_f);
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- source/serial_alu_core.sv
/*
 * Nibble-serial execution core with a 16 entry register file.
 * Takes one decoded instruction when idle and spends 8 cycles on it,
 * retiring in the last one. Illegal instructions spend a single cycle.
 */
`default_nettype none

module serial_alu_core (
    input  wire                                  clk,
    input  wire                                  rstn,
    input  wire                                  instr_avail,
    input  wire rv_isa_pkg::alu_op_t             alu_op,
    input  wire rv_isa_pkg::src_b_t              src_b,
    input  wire  [rv_isa_pkg::REG_ADDR_BITS-1:0] rs1,
    input  wire  [rv_isa_pkg::REG_ADDR_BITS-1:0] rs2,
    input  wire  [rv_isa_pkg::REG_ADDR_BITS-1:0] rd,
    input  wire  [rv_isa_pkg::XLEN-1:0]          imm,
    input  wire                                  illegal,
    output logic                                 instr_take,
    output logic                                 retire_valid,
    output logic [rv_isa_pkg::REG_ADDR_BITS-1:0] retire_rd,
    output logic [rv_isa_pkg::XLEN-1:0]          retire_value,
    output logic                                 illegal_instr
);

    localparam int CNT_W = $clog2(rv_isa_pkg::NIBBLES);

    logic [rv_isa_pkg::XLEN-1:0]          regs [rv_isa_pkg::NUM_REGS];

    rv_isa_pkg::alu_op_t                  op_q;
    rv_isa_pkg::src_b_t                   src_b_q;
    logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rs1_q;
    logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rs2_q;
    logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rd_q;
    logic [rv_isa_pkg::XLEN-1:0]          imm_q;

    logic                                 busy;
    logic                                 ill_q;
    logic [CNT_W-1:0]                     cnt;
    logic                                 carry_q;
    logic [rv_isa_pkg::XLEN-1:0]          result_q;

    logic                                 last;
    logic [rv_isa_pkg::XLEN-1:0]          a_word;
    logic [rv_isa_pkg::XLEN-1:0]          b_word;
    logic [3:0]                           a_nib;
    logic [3:0]                           b_nib;
    logic [3:0]                           b_add;
    logic [4:0]                           sum;
    logic [3:0]                           res_nib;
    logic [rv_isa_pkg::XLEN-1:0]          final_value;

    assign instr_take = instr_avail && !busy && !ill_q;
    assign last       = busy && (cnt == CNT_W'(rv_isa_pkg::NIBBLES - 1));

    // Register file only changes at the end of an instruction, so operands are read live
    always_comb begin
        a_word = (rs1_q == '0) ? '0 : regs[rs1_q];
        if (src_b_q == rv_isa_pkg::src_imm) begin
            b_word = imm_q;
        end else begin
            b_word = (rs2_q == '0) ? '0 : regs[rs2_q];
        end

        a_nib = a_word[{cnt, 2'b00} +: 4];
        b_nib = b_word[{cnt, 2'b00} +: 4];
        b_add = (op_q == rv_isa_pkg::op_sub) ? ~b_nib : b_nib;  // Carry starts at 1 for SUB
        sum   = {1'b0, a_nib} + {1'b0, b_add} + {4'b0, carry_q};

        case (op_q)
            rv_isa_pkg::op_add, rv_isa_pkg::op_sub: res_nib = sum[3:0];
            rv_isa_pkg::op_and:                     res_nib = a_nib & b_nib;
            rv_isa_pkg::op_or:                      res_nib = a_nib | b_nib;
            rv_isa_pkg::op_xor:                     res_nib = a_nib ^ b_nib;
            default:                                res_nib = b_nib;
        endcase
    end

    assign final_value = {res_nib, result_q[rv_isa_pkg::XLEN-1:4]};

    always_ff @(posedge clk) begin
        if (instr_take) begin
            op_q    <= alu_op;
            src_b_q <= src_b;
            rs1_q   <= rs1;
            rs2_q   <= rs2;
            rd_q    <= rd;
            imm_q   <= imm;
            carry_q <= (alu_op == rv_isa_pkg::op_sub);
        end else if (busy) begin
            carry_q  <= sum[4];
            result_q <= final_value;  // Nibbles shift in from the top
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy  <= 1'b0;
            ill_q <= 1'b0;
            cnt   <= '0;
        end else begin
            ill_q <= instr_take && illegal;
            if (instr_take) begin
                busy <= !illegal;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (last && rd_q != '0) begin
            regs[rd_q] <= final_value;
        end
    end

    assign retire_valid  = last;
    assign retire_rd     = rd_q;
    assign retire_value  = (rd_q == '0) ? '0 : final_value;
    assign illegal_instr = ill_q;

    a_retire_or_illegal: assert property (@(posedge clk) disable iff (!rstn)
        retire_valid |-> !illegal_instr);

endmodule

`default_nettype wire

//--- source/serial_cpu_top.sv
/*
 * Top level of the serial execution subsystem.
 * Halfwords come in under credit flow control and results leave on the retire port.
 */
`default_nettype none

module serial_cpu_top (
    input  wire         clk,
    input  wire         rstn,
    input  wire         fetch_valid,
    input  wire  [15:0] fetch_data,
    output logic        fetch_credit,
    output logic        retire_valid,
    output logic [3:0]  retire_rd,
    output logic [31:0] retire_value,
    output logic        illegal_instr
);

    logic                instr_avail;
    logic                instr_take;
    logic [31:0]         instr_word;

    rv_isa_pkg::alu_op_t alu_op;
    rv_isa_pkg::src_b_t  src_b;
    logic [3:0]          rs1;
    logic [3:0]          rs2;
    logic [3:0]          rd;
    logic [31:0]         imm;
    logic                illegal;

    instr_prefetch i_prefetch (
        .clk          (clk),
        .rstn         (rstn),
        .fetch_valid  (fetch_valid),
        .fetch_data   (fetch_data),
        .instr_take   (instr_take),
        .fetch_credit (fetch_credit),
        .instr_avail  (instr_avail),
        .instr_word   (instr_word)
    );

    instr_decoder i_decoder (
        .instr_word (instr_word),
        .alu_op     (alu_op),
        .src_b      (src_b),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .imm        (imm),
        .illegal    (illegal)
    );

    serial_alu_core i_core (
        .clk           (clk),
        .rstn          (rstn),
        .instr_avail   (instr_avail),
        .alu_op        (alu_op),
        .src_b         (src_b),
        .rs1           (rs1),
        .rs2           (rs2),
        .rd            (rd),
        .imm           (imm),
        .illegal       (illegal),
        .instr_take    (instr_take),
        .retire_valid  (retire_valid),
        .retire_rd     (retire_rd),
        .retire_value  (retire_value),
        .illegal_instr (illegal_instr)
    );

endmodule

`default_nettype wire

//--- verif/cpu_checker.sv
/*
 * Watches the fetch and retire ports of the serial CPU. Tracks the credits
 * held by the fetch source and compares every retire or illegal event, in
 * order, with the expected table handed in by the testbench.
 */
`default_nettype none

module cpu_checker #(
    parameter int NUM_ROWS = 1
) (
    input  wire        clk,
    input  wire        rstn,
    input  wire        fetch_valid,
    input  wire        fetch_credit,
    input  wire        retire_valid,
    input  wire [3:0]  retire_rd,
    input  wire [31:0] retire_value,
    input  wire        illegal_instr,
    input  wire        row_ill [NUM_ROWS],
    input  wire [3:0]  row_rd  [NUM_ROWS],
    input  wire [31:0] row_val [NUM_ROWS],
    output int         events_seen,
    output int         value_errors,
    output int         protocol_errors
);

    int credits = fetch_pkg::FETCH_DEPTH;
    bit reset_seen;

    task automatic compare_value(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %0h, got %0h (row %0d)",
                $time, name, expected, actual, events_seen);
            value_errors++;
        end
    endtask

    task automatic protocol_error(input string what);
        $display("Protocol error at %0t: %s", $time, what);
        protocol_errors++;
    endtask

    task automatic check_event();
        if (events_seen >= NUM_ROWS) begin
            protocol_error("retire or illegal event beyond the end of the table");
        end else begin
            if (row_ill[events_seen]) begin
                compare_value("illegal_instr", 32'd1, {31'b0, illegal_instr});
                compare_value("retire_valid", 32'd0, {31'b0, retire_valid});
            end else begin
                compare_value("retire_valid", 32'd1, {31'b0, retire_valid});
                compare_value("illegal_instr", 32'd0, {31'b0, illegal_instr});
                compare_value("retire_rd", {28'b0, row_rd[events_seen]}, {28'b0, retire_rd});
                compare_value("retire_value", row_val[events_seen], retire_value);
            end
            // By the last retire every halfword has left the FIFO
            if (events_seen == NUM_ROWS - 1 && credits != fetch_pkg::FETCH_DEPTH) begin
                protocol_error("credits not back at the FIFO depth after the last row");
            end
            events_seen++;
        end
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            // Outputs are unknown until the first reset edge has passed
            if (reset_seen && (fetch_credit !== 1'b0 || retire_valid !== 1'b0
                    || illegal_instr !== 1'b0)) begin
                protocol_error("output active during reset");
            end
            reset_seen = 1'b1;
            credits    = fetch_pkg::FETCH_DEPTH;
        end else begin
            if (fetch_credit === 1'b1) begin
                credits++;
                if (credits > fetch_pkg::FETCH_DEPTH) begin
                    protocol_error("credit returned that was never spent");
                end
            end
            if (fetch_valid === 1'b1) begin
                if (credits == 0) begin
                    protocol_error("halfword sent with no credit left");
                end
                credits--;
            end
            if (retire_valid === 1'b1 || illegal_instr === 1'b1) begin
                check_event();
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_serial_cpu.sv
/*
 * Testbench for the serial CPU. A credit-tracking fetch source streams a
 * table of instructions as halfwords, first with random idle cycles and then
 * back to back, while cpu_checker compares the results with the table.
 */
`default_nettype none

module tb_serial_cpu;

    localparam int NUM_ROWS       = 24;
    localparam int PHASE2_ROW     = 12;  // From this row on the source never idles
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (2 * rv_isa_pkg::NIBBLES + 4) + 100;

    logic        clk;
    logic        rstn;
    logic        fetch_valid;
    logic [15:0] fetch_data;
    logic        fetch_credit;
    logic        retire_valid;
    logic [3:0]  retire_rd;
    logic [31:0] retire_value;
    logic        illegal_instr;

    logic [31:0] row_word [NUM_ROWS];
    logic        row_ill  [NUM_ROWS];
    logic [3:0]  row_rd   [NUM_ROWS];
    logic [31:0] row_val  [NUM_ROWS];
    int          row_n;
    integer      seed;
    int          src_credits;
    int          events_seen;
    int          value_errors;
    int          protocol_errors;
    int          cycles;
    bit          timed_out;

    serial_cpu_top i_serial_cpu_top (
        .clk           (clk),
        .rstn          (rstn),
        .fetch_valid   (fetch_valid),
        .fetch_data    (fetch_data),
        .fetch_credit  (fetch_credit),
        .retire_valid  (retire_valid),
        .retire_rd     (retire_rd),
        .retire_value  (retire_value),
        .illegal_instr (illegal_instr)
    );

    cpu_checker #(.NUM_ROWS(NUM_ROWS)) i_checker (
        .clk             (clk),
        .rstn            (rstn),
        .fetch_valid     (fetch_valid),
        .fetch_credit    (fetch_credit),
        .retire_valid    (retire_valid),
        .retire_rd       (retire_rd),
        .retire_value    (retire_value),
        .illegal_instr   (illegal_instr),
        .row_ill         (row_ill),
        .row_rd          (row_rd),
        .row_val         (row_val),
        .events_seen     (events_seen),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors)
    );

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rv_isa_pkg::OPC_LUI};
    endfunction

    task automatic push_retire(input logic [31:0] word, input logic [3:0] rd,
            input logic [31:0] val);
        row_word[row_n] = word;
        row_ill[row_n]  = 1'b0;
        row_rd[row_n]   = rd;
        row_val[row_n]  = val;
        row_n++;
    endtask

    task automatic illegal_row(input logic [31:0] word);
        row_word[row_n] = word;
        row_ill[row_n]  = 1'b1;
        row_rd[row_n]   = '0;
        row_val[row_n]  = '0;
        row_n++;
    endtask

    // Expected values follow the rows in order, starting from all-zero registers
    task automatic build_table();
        push_retire(r_type_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd0), 4'd0, 32'h0000_0000);
        push_retire(lui_word(20'h12345, 5'd1), 4'd1, 32'h1234_5000);
        push_retire(i_type_word(12'h678, 5'd1, 3'b000, 5'd1), 4'd1, 32'h1234_5678);
        push_retire(i_type_word(12'hFFF, 5'd0, 3'b000, 5'd2), 4'd2, 32'hFFFF_FFFF);
        push_retire(i_type_word(12'h0F0, 5'd0, 3'b000, 5'd3), 4'd3, 32'h0000_00F0);
        push_retire(r_type_word(7'h00, 5'd3, 5'd1, 3'b000, 5'd4), 4'd4, 32'h1234_5768);
        push_retire(r_type_word(7'h20, 5'd1, 5'd3, 3'b000, 5'd5), 4'd5, 32'hEDCB_AA78);
        push_retire(r_type_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd6), 4'd6, 32'h1234_5678);
        push_retire(r_type_word(7'h00, 5'd3, 5'd1, 3'b110, 5'd7), 4'd7, 32'h1234_56F8);
        push_retire(r_type_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd8), 4'd8, 32'hEDCB_A987);
        push_retire(i_type_word(12'h800, 5'd1, 3'b000, 5'd9), 4'd9, 32'h1234_4E78);
        push_retire(i_type_word(12'hFF0, 5'd2, 3'b111, 5'd10), 4'd10, 32'hFFFF_FFF0);
        push_retire(i_type_word(12'h80F, 5'd3, 3'b110, 5'd11), 4'd11, 32'hFFFF_F8FF);
        push_retire(i_type_word(12'hFFF, 5'd1, 3'b100, 5'd12), 4'd12, 32'hEDCB_A987);
        push_retire(i_type_word(12'h005, 5'd1, 3'b000, 5'd0), 4'd0, 32'h0000_0000);
        push_retire(r_type_word(7'h00, 5'd1, 5'd0, 3'b000, 5'd13), 4'd13, 32'h1234_5678);
        illegal_row(32'h0020_8063);  // A branch, which this core does not support
        illegal_row(r_type_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd16));
        illegal_row(i_type_word(12'h001, 5'd17, 3'b000, 5'd5));
        push_retire(r_type_word(7'h20, 5'd1, 5'd2, 3'b000, 5'd14), 4'd14, 32'hEDCB_A987);
        push_retire(r_type_word(7'h00, 5'd7, 5'd14, 3'b100, 5'd15), 4'd15, 32'hFFFF_FF7F);
        push_retire(r_type_word(7'h00, 5'd0, 5'd5, 3'b110, 5'd5), 4'd5, 32'hEDCB_AA78);
        push_retire(lui_word(20'hFFFFF, 5'd6), 4'd6, 32'hFFFF_F000);
        push_retire(r_type_word(7'h00, 5'd9, 5'd6, 3'b000, 5'd6), 4'd6, 32'h1234_3E78);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // The fetch source sends the lower halfword first and spends one credit per halfword
    initial begin
        bit sent;
        bit idle;
        seed        = 32'h69c5a4b7;
        rstn        = 1'b0;
        fetch_valid = 1'b0;
        fetch_data  = '0;
        src_credits = fetch_pkg::FETCH_DEPTH;
        build_table();
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        for (int h = 0; h < 2 * NUM_ROWS; h++) begin
            sent = 1'b0;
            while (!sent) begin
                @(negedge clk);
                if (fetch_credit) begin
                    src_credits++;
                end
                fetch_valid = 1'b0;
                idle = (h < 2 * PHASE2_ROW) && (($random(seed) & 1) != 0);
                // Without idle cycles the core falls behind and the FIFO fills up
                if (src_credits > 0 && !idle) begin
                    fetch_valid = 1'b1;
                    fetch_data  = h[0] ? row_word[h / 2][31:16] : row_word[h / 2][15:0];
                    src_credits--;
                    sent = 1'b1;
                end
            end
        end
        @(negedge clk);
        fetch_valid = 1'b0;
    end

    initial begin
        cycles    = 0;
        timed_out = 1'b0;
        while (events_seen < NUM_ROWS && !timed_out) begin
            @(negedge clk);
            cycles++;
            timed_out = (cycles >= TIMEOUT_CYCLES);
        end
        repeat (rv_isa_pkg::NIBBLES + 2) @(negedge clk);  // Room for a stray event
        if (timed_out) begin
            $display("Timeout after %0d cycles with %0d of %0d events seen",
                cycles, events_seen, NUM_ROWS);
        end
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (!timed_out && value_errors == 0 && protocol_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tiny_serial_cpu.f
source/rv_isa_pkg.sv
source/fetch_pkg.sv
source/instr_prefetch.sv
source/instr_decoder.sv
source/serial_alu_core.sv
source/serial_cpu_top.sv
verif/cpu_checker.sv
verif/tb_serial_cpu.sv

//--- Makefile
TOP := tb_serial_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tiny_serial_cpu.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tiny_serial_cpu.f --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir
